/* design/alu_unit.sv */
// ====================================================================
// ALU
// combinational result for the ten RV32I integer operations
// ====================================================================

`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module alu_unit import core_pkg::*; (
    input  logic [`XLEN-1:0] ex_op1_i,
    input  logic [`XLEN-1:0] ex_op2_i,
    input  alu_op_e          ex_alu_op_i,
    output logic [`XLEN-1:0] result_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = ex_op2_i[4:0]; // low five bits only
    assign lt_signed   = $signed(ex_op1_i) < $signed(ex_op2_i);
    assign lt_unsigned = ex_op1_i < ex_op2_i;

    always_comb begin
        case (ex_alu_op_i)
            ADD:     result_o = ex_op1_i + ex_op2_i;
            SUB:     result_o = ex_op1_i - ex_op2_i;
            SLL:     result_o = ex_op1_i << shamt;
            SLT:     result_o = {{(`XLEN-1){1'b0}}, lt_signed};
            SLTU:    result_o = {{(`XLEN-1){1'b0}}, lt_unsigned};
            XOR:     result_o = ex_op1_i ^ ex_op2_i;
            SRL:     result_o = ex_op1_i >> shamt;
            SRA:     result_o = $unsigned($signed(ex_op1_i) >>> shamt);
            OR:      result_o = ex_op1_i | ex_op2_i;
            AND:     result_o = ex_op1_i & ex_op2_i;
            default: result_o = '0; // unused encodings
        endcase
    end

endmodule

`default_nettype wire

/* design/core_config.svh */
// ====================================================================
// core configuration
// widths and sizes shared by the integer datapath
// ====================================================================

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data path width
`define XLEN 32

// register index width
`define REG_ADDR_WIDTH 5

// general purpose registers, x0 included
`define REG_NUM 32

`endif

/* design/core_pkg.sv */
// ====================================================================
// core package
// opcode and ALU operation encodings of the integer core
// ====================================================================

`default_nettype none

package core_pkg;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011
    } opcode_e;

    // ALU operations; LUI runs as ADD with op1 forced to zero
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_op_e;

endpackage

`default_nettype wire

/* design/core_top.sv */
// ====================================================================
// core top
// decode, dispatch, ALU and writeback of the RV32I integer subset
// one instruction strobe in, one retire strobe out 3 cycles later
// ====================================================================

`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module core_top import core_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       inst_valid_i,
    input  logic [`XLEN-1:0]           inst_i,
    output logic                       retire_valid_o,
    output logic                       retire_illegal_o,
    output logic                       retire_we_o,
    output logic [`REG_ADDR_WIDTH-1:0] retire_rd_o,
    output logic [`XLEN-1:0]           retire_data_o
);

    // decode record
    logic                       dec_valid;
    logic                       dec_illegal;
    logic [`REG_ADDR_WIDTH-1:0] dec_rd;
    logic [`REG_ADDR_WIDTH-1:0] dec_rs1;
    logic [`REG_ADDR_WIDTH-1:0] dec_rs2;
    logic                       dec_use_rs1;
    logic                       dec_use_imm;
    logic [`XLEN-1:0]           dec_imm;
    alu_op_e                    dec_alu_op;

    // register file read side
    logic [`REG_ADDR_WIDTH-1:0] gpr_raddr1;
    logic [`REG_ADDR_WIDTH-1:0] gpr_raddr2;
    logic [`XLEN-1:0]           gpr_rdata1;
    logic [`XLEN-1:0]           gpr_rdata2;

    // execute stage
    logic                       ex_valid;
    logic                       ex_illegal;
    logic [`REG_ADDR_WIDTH-1:0] ex_rd;
    logic [`XLEN-1:0]           ex_op1;
    logic [`XLEN-1:0]           ex_op2;
    alu_op_e                    ex_alu_op;
    logic [`XLEN-1:0]           alu_result;

    // retire register, also the forwarding source
    logic                       gpr_we;
    logic [`REG_ADDR_WIDTH-1:0] gpr_waddr;
    logic [`XLEN-1:0]           gpr_wdata;

    inst_decoder u_inst_decoder (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .dec_valid_o  (dec_valid),
        .dec_illegal_o(dec_illegal),
        .dec_rd_o     (dec_rd),
        .dec_rs1_o    (dec_rs1),
        .dec_rs2_o    (dec_rs2),
        .dec_use_rs1_o(dec_use_rs1),
        .dec_use_imm_o(dec_use_imm),
        .dec_imm_o    (dec_imm),
        .dec_alu_op_o (dec_alu_op)
    );

    gpr_file u_gpr_file (
        .clk     (clk),
        .rst_i   (rst_i),
        .we_i    (gpr_we),
        .waddr_i (gpr_waddr),
        .wdata_i (gpr_wdata),
        .raddr1_i(gpr_raddr1),
        .raddr2_i(gpr_raddr2),
        .rdata1_o(gpr_rdata1),
        .rdata2_o(gpr_rdata2)
    );

    operand_dispatch u_operand_dispatch (
        .clk               (clk),
        .rst_i             (rst_i),
        .dec_valid_i       (dec_valid),
        .dec_illegal_i     (dec_illegal),
        .dec_rd_i          (dec_rd),
        .dec_rs1_i         (dec_rs1),
        .dec_rs2_i         (dec_rs2),
        .dec_use_rs1_i     (dec_use_rs1),
        .dec_use_imm_i     (dec_use_imm),
        .dec_imm_i         (dec_imm),
        .dec_alu_op_i      (dec_alu_op),
        .gpr_rdata1_i      (gpr_rdata1),
        .gpr_rdata2_i      (gpr_rdata2),
        .ex_fwd_data_i     (alu_result),
        .retire_fwd_valid_i(gpr_we),
        .retire_fwd_rd_i   (gpr_waddr),
        .retire_fwd_data_i (gpr_wdata),
        .gpr_raddr1_o      (gpr_raddr1),
        .gpr_raddr2_o      (gpr_raddr2),
        .ex_valid_o        (ex_valid),
        .ex_illegal_o      (ex_illegal),
        .ex_rd_o           (ex_rd),
        .ex_op1_o          (ex_op1),
        .ex_op2_o          (ex_op2),
        .ex_alu_op_o       (ex_alu_op)
    );

    alu_unit u_alu_unit (
        .ex_op1_i   (ex_op1),
        .ex_op2_i   (ex_op2),
        .ex_alu_op_i(ex_alu_op),
        .result_o   (alu_result)
    );

    writeback_stage u_writeback_stage (
        .clk             (clk),
        .rst_i           (rst_i),
        .ex_valid_i      (ex_valid),
        .ex_illegal_i    (ex_illegal),
        .ex_rd_i         (ex_rd),
        .alu_result_i    (alu_result),
        .retire_valid_o  (retire_valid_o),
        .retire_illegal_o(retire_illegal_o),
        .retire_we_o     (retire_we_o),
        .retire_rd_o     (retire_rd_o),
        .retire_data_o   (retire_data_o),
        .gpr_we_o        (gpr_we),
        .gpr_waddr_o     (gpr_waddr),
        .gpr_wdata_o     (gpr_wdata)
    );

endmodule

`default_nettype wire

/* design/gpr_file.sv */
// ====================================================================
// general purpose register file
// 32 x XLEN, two combinational reads, one write, x0 reads zero
// ====================================================================

`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module gpr_file (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       we_i,
    input  logic [`REG_ADDR_WIDTH-1:0] waddr_i,
    input  logic [`XLEN-1:0]           wdata_i,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr1_i,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr2_i,
    output logic [`XLEN-1:0]           rdata1_o,
    output logic [`XLEN-1:0]           rdata2_o
);

    logic [`XLEN-1:0] regs [`REG_NUM];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin // x0 never written
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

/* design/inst_decoder.sv */
// ====================================================================
// instruction decoder
// checks an RV32I word against LUI, OP-IMM and OP, builds the
// immediate and ALU operation, registers the record with its valid
// ====================================================================

`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module inst_decoder import core_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       inst_valid_i,
    input  logic [`XLEN-1:0]           inst_i,
    output logic                       dec_valid_o,
    output logic                       dec_illegal_o,
    output logic [`REG_ADDR_WIDTH-1:0] dec_rd_o,
    output logic [`REG_ADDR_WIDTH-1:0] dec_rs1_o,
    output logic [`REG_ADDR_WIDTH-1:0] dec_rs2_o,
    output logic                       dec_use_rs1_o,
    output logic                       dec_use_imm_o,
    output logic [`XLEN-1:0]           dec_imm_o,
    output alu_op_e                    dec_alu_op_o
);

    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic             illegal;
    logic             use_rs1;
    logic             use_imm;
    logic [`XLEN-1:0] imm;
    alu_op_e          alu_op;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    always_comb begin
        illegal = 1'b0;
        use_rs1 = 1'b1;
        use_imm = 1'b1;
        imm     = {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]}; // I-type
        alu_op  = ADD;
        case (opcode)
            LUI: begin
                use_rs1 = 1'b0; // op1 becomes zero in dispatch
                imm     = {inst_i[31:12], 12'b0};
            end
            OP_IMM: begin
                case (funct3)
                    3'b000: alu_op = ADD;
                    3'b010: alu_op = SLT;
                    3'b011: alu_op = SLTU;
                    3'b100: alu_op = XOR;
                    3'b110: alu_op = OR;
                    3'b111: alu_op = AND;
                    3'b001: begin
                        alu_op  = SLL;
                        illegal = (funct7 != 7'b0000000);
                    end
                    default: begin // srli / srai
                        alu_op  = funct7[5] ? SRA : SRL;
                        illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    end
                endcase
                // shift amount only, drops the srai marker bit
                if (funct3[1:0] == 2'b01) begin
                    imm = {{(`XLEN-5){1'b0}}, inst_i[24:20]};
                end
            end
            OP: begin
                use_imm = 1'b0;
                case (funct3)
                    3'b000:  alu_op = funct7[5] ? SUB : ADD;
                    3'b001:  alu_op = SLL;
                    3'b010:  alu_op = SLT;
                    3'b011:  alu_op = SLTU;
                    3'b100:  alu_op = XOR;
                    3'b101:  alu_op = funct7[5] ? SRA : SRL;
                    3'b110:  alu_op = OR;
                    default: alu_op = AND;
                endcase
                // funct7 0100000 only legal for sub and sra
                illegal = !((funct7 == 7'b0000000) ||
                            ((funct7 == 7'b0100000) &&
                             ((funct3 == 3'b000) || (funct3 == 3'b101))));
            end
            default: illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= inst_valid_i;
        end
    end

    // record is only looked at while dec_valid_o is high
    always_ff @(posedge clk) begin
        dec_illegal_o <= illegal;
        dec_rd_o      <= inst_i[11:7];
        dec_rs1_o     <= inst_i[19:15];
        dec_rs2_o     <= inst_i[24:20];
        dec_use_rs1_o <= use_rs1;
        dec_use_imm_o <= use_imm;
        dec_imm_o     <= imm;
        dec_alu_op_o  <= alu_op;
    end

endmodule

`default_nettype wire

/* design/operand_dispatch.sv */
// ====================================================================
// operand dispatch
// reads the sources, forwards from execute and retire, registers
// the ALU request for the execute stage
// ====================================================================

`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module operand_dispatch import core_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       dec_valid_i,
    input  logic                       dec_illegal_i,
    input  logic [`REG_ADDR_WIDTH-1:0] dec_rd_i,
    input  logic [`REG_ADDR_WIDTH-1:0] dec_rs1_i,
    input  logic [`REG_ADDR_WIDTH-1:0] dec_rs2_i,
    input  logic                       dec_use_rs1_i,
    input  logic                       dec_use_imm_i,
    input  logic [`XLEN-1:0]           dec_imm_i,
    input  alu_op_e                    dec_alu_op_i,
    input  logic [`XLEN-1:0]           gpr_rdata1_i,
    input  logic [`XLEN-1:0]           gpr_rdata2_i,
    input  logic [`XLEN-1:0]           ex_fwd_data_i,
    input  logic                       retire_fwd_valid_i,
    input  logic [`REG_ADDR_WIDTH-1:0] retire_fwd_rd_i,
    input  logic [`XLEN-1:0]           retire_fwd_data_i,
    output logic [`REG_ADDR_WIDTH-1:0] gpr_raddr1_o,
    output logic [`REG_ADDR_WIDTH-1:0] gpr_raddr2_o,
    output logic                       ex_valid_o,
    output logic                       ex_illegal_o,
    output logic [`REG_ADDR_WIDTH-1:0] ex_rd_o,
    output logic [`XLEN-1:0]           ex_op1_o,
    output logic [`XLEN-1:0]           ex_op2_o,
    output alu_op_e                    ex_alu_op_o
);

    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;

    // youngest producer wins: execute, then retire, then register file
    function automatic logic [`XLEN-1:0] pick_src(
        input logic [`REG_ADDR_WIDTH-1:0] rs,
        input logic [`XLEN-1:0]           gpr_val
    );
        logic [`XLEN-1:0] val;
        val = gpr_val;
        if (rs == '0) begin
            val = '0;
        end else if (ex_valid_o && !ex_illegal_o && (ex_rd_o == rs)) begin
            val = ex_fwd_data_i;
        end else if (retire_fwd_valid_i && (retire_fwd_rd_i == rs)) begin
            val = retire_fwd_data_i;
        end
        return val;
    endfunction

    assign gpr_raddr1_o = dec_rs1_i;
    assign gpr_raddr2_o = dec_rs2_i;

    always_comb begin
        rs1_val = pick_src(dec_rs1_i, gpr_rdata1_i);
        rs2_val = pick_src(dec_rs2_i, gpr_rdata2_i);
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        ex_illegal_o <= dec_illegal_i;
        ex_rd_o      <= dec_rd_i;
        ex_op1_o     <= dec_use_rs1_i ? rs1_val : '0; // zero for lui
        ex_op2_o     <= dec_use_imm_i ? dec_imm_i : rs2_val;
        ex_alu_op_o  <= dec_alu_op_i;
    end

endmodule

`default_nettype wire

/* design/writeback_stage.sv */
// ====================================================================
// writeback stage
// retire register driving the retire strobe and the register write
// ====================================================================

`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module writeback_stage (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       ex_valid_i,
    input  logic                       ex_illegal_i,
    input  logic [`REG_ADDR_WIDTH-1:0] ex_rd_i,
    input  logic [`XLEN-1:0]           alu_result_i,
    output logic                       retire_valid_o,
    output logic                       retire_illegal_o,
    output logic                       retire_we_o,
    output logic [`REG_ADDR_WIDTH-1:0] retire_rd_o,
    output logic [`XLEN-1:0]           retire_data_o,
    output logic                       gpr_we_o,
    output logic [`REG_ADDR_WIDTH-1:0] gpr_waddr_o,
    output logic [`XLEN-1:0]           gpr_wdata_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            retire_valid_o <= 1'b0;
            retire_we_o    <= 1'b0;
        end else begin
            retire_valid_o <= ex_valid_i;
            // nothing written for illegal words or rd = x0
            retire_we_o    <= ex_valid_i && !ex_illegal_i && (ex_rd_i != '0);
        end
    end

    always_ff @(posedge clk) begin
        retire_illegal_o <= ex_illegal_i;
        retire_rd_o      <= ex_rd_i;
        retire_data_o    <= ex_illegal_i ? '0 : alu_result_i;
    end

    // register file is written at the end of the retire cycle
    assign gpr_we_o    = retire_we_o;
    assign gpr_waddr_o = retire_rd_o;
    assign gpr_wdata_o = retire_data_o;

endmodule

`default_nettype wire

/* project.f */
+incdir+design
design/core_pkg.sv
design/inst_decoder.sv
design/gpr_file.sv
design/operand_dispatch.sv
design/alu_unit.sv
design/writeback_stage.sv
design/core_top.sv
tb/core_tb.sv

/* tb/core_tb.sv */
// ====================================================================
// core testbench
// random RV32I stream with dependencies and illegal words, checked
// against a register model, retire timing and strobe counts
// ====================================================================

`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module core_tb;

    localparam int          NUM_INST    = 2000;
    localparam int          CLK_PERIOD  = 4;
    localparam int          WATCHDOG_NS = (NUM_INST * 2 + 100) * CLK_PERIOD;
    localparam logic [31:0] LFSR_SEED   = 32'h6b80_fc56;
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;
    localparam logic [6:0]  OPC_LUI     = 7'b0110111;
    localparam logic [6:0]  OPC_OP_IMM  = 7'b0010011;
    localparam logic [6:0]  OPC_OP      = 7'b0110011;

    localparam int T_TIMING  = 0;
    localparam int T_ALU     = 1;
    localparam int T_LUI_X0  = 2;
    localparam int T_FWD     = 3;
    localparam int T_ILLEGAL = 4;
    localparam int T_COUNTS  = 5;
    localparam int NUM_TESTS = 6;

    typedef struct packed {
        logic                       illegal;
        logic                       we;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`XLEN-1:0]           data;
        logic [31:0]                cycle;
        logic [2:0]                 test;
    } retire_t;

    logic                       clk;
    logic                       rst_i;
    logic                       inst_valid_i;
    logic [`XLEN-1:0]           inst_i;
    logic                       retire_valid_o;
    logic                       retire_illegal_o;
    logic                       retire_we_o;
    logic [`REG_ADDR_WIDTH-1:0] retire_rd_o;
    logic [`XLEN-1:0]           retire_data_o;

    logic [31:0]      lfsr_state = LFSR_SEED;
    logic [`XLEN-1:0] model_regs [`REG_NUM];
    logic [2:0]       hist_rd [3];    // written rd of the last three strobes
    retire_t          exp_q [$];
    int               checks [NUM_TESTS];
    int               errors [NUM_TESTS];
    int               cycle_cnt  = 0;
    int               strobe_cnt = 0;
    int               retire_cnt = 0;

    core_top core_top_inst (
        .clk             (clk),
        .rst_i           (rst_i),
        .inst_valid_i    (inst_valid_i),
        .inst_i          (inst_i),
        .retire_valid_o  (retire_valid_o),
        .retire_illegal_o(retire_illegal_o),
        .retire_we_o     (retire_we_o),
        .retire_rd_o     (retire_rd_o),
        .retire_data_o   (retire_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // galois lfsr stepped once per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            T_TIMING:  return "reset_timing";
            T_ALU:     return "alu_results";
            T_LUI_X0:  return "lui_x0";
            T_FWD:     return "forwarding";
            T_ILLEGAL: return "illegal_words";
            default:   return "retire_counts";
        endcase
    endfunction

    // op codes 0..9 are add sub sll slt sltu xor srl sra or and
    function automatic logic [2:0] op_funct3(input int op);
        case (op)
            0, 1:    return 3'd0;
            2:       return 3'd1;
            3:       return 3'd2;
            4:       return 3'd3;
            5:       return 3'd4;
            6, 7:    return 3'd5;
            8:       return 3'd6;
            default: return 3'd7;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] model_alu(input int op, input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b);
        case (op)
            0:       return a + b;
            1:       return a - b;
            2:       return a << b[4:0];
            3:       return ($signed(a) < $signed(b)) ? 1 : 0;
            4:       return (a < b) ? 1 : 0;
            5:       return a ^ b;
            6:       return a >> b[4:0];
            7:       return $signed(a) >>> b[4:0];
            8:       return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_value(input int t, input string what, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        checks[t]++;
        assert (exp_val === act_val) else begin
            $display("error: %s %s expected %h actual %h", test_name(t), what, exp_val, act_val);
            errors[t]++;
        end
    endtask

    // builds one random word, runs it on the model and drives the strobe
    task automatic issue_instruction();
        logic [`XLEN-1:0] word;
        logic [`XLEN-1:0] op_a;
        logic [`XLEN-1:0] op_b;
        logic [11:0]      imm12;
        logic [19:0]      imm20;
        logic [6:0]       funct7;
        logic [2:0]       rd;
        logic [2:0]       rs1;
        logic [2:0]       rs2;
        logic             use1;
        logic             use2;
        int               op;
        retire_t          rec;
        rd   = take_bits(3);
        rs1  = take_bits(3);
        rs2  = take_bits(3);
        use1 = 1'b1;
        use2 = 1'b0;
        rec  = '0;
        if (take_bits(4) == 0) begin
            word = take_bits(32);
            use1 = 1'b0;
            // bit 0 low is never a supported opcode
            if (word[0]) begin
                word[6:0] = OPC_OP;
                word[25]  = 1'b1;   // funct7 outside the base set
            end
            rec.illegal = 1'b1;
        end else begin
            case (take_bits(2))
                0: begin
                    imm20    = take_bits(20);
                    word     = {imm20, 2'b00, rd, OPC_LUI};
                    use1     = 1'b0;
                    rec.data = {{(`XLEN-20){1'b0}}, imm20} << 12;
                end
                1: begin
                    op = take_bits(4) % 9;
                    if (op >= 1) op++;  // no subi
                    funct7 = (op == 7) ? 7'b0100000 : 7'b0000000;
                    imm12  = take_bits(12);
                    if (op == 2 || op == 6 || op == 7) imm12 = {funct7, imm12[4:0]};
                    word     = {imm12, 2'b00, rs1, op_funct3(op), 2'b00, rd, OPC_OP_IMM};
                    op_a     = model_regs[rs1];
                    op_b     = {{(`XLEN-12){imm12[11]}}, imm12};
                    rec.data = model_alu(op, op_a, op_b);
                end
                default: begin
                    op     = take_bits(4) % 10;
                    funct7 = (op == 1 || op == 7) ? 7'b0100000 : 7'b0000000;
                    use2   = 1'b1;
                    word     = {funct7, 2'b00, rs2, 2'b00, rs1, op_funct3(op), 2'b00, rd, OPC_OP};
                    rec.data = model_alu(op, model_regs[rs1], model_regs[rs2]);
                end
            endcase
        end
        rec.we    = !rec.illegal && (rd != 0);
        rec.rd    = {2'b00, rd};
        rec.cycle = cycle_cnt + 3;
        if (rec.illegal) rec.test = T_ILLEGAL;
        else if (!use1 || rd == 0) rec.test = T_LUI_X0;
        else if ((rs1 != 0 && (rs1 == hist_rd[0] || rs1 == hist_rd[1] || rs1 == hist_rd[2])) ||
                 (use2 && rs2 != 0 && (rs2 == hist_rd[0] || rs2 == hist_rd[1] ||
                                        rs2 == hist_rd[2])))
            rec.test = T_FWD;
        else rec.test = T_ALU;
        if (rec.we) model_regs[rd] = rec.data;
        hist_rd[2] = hist_rd[1];
        hist_rd[1] = hist_rd[0];
        hist_rd[0] = rec.we ? rd : 3'd0;
        exp_q.push_back(rec);
        strobe_cnt++;
        inst_valid_i = 1'b1;
        inst_i       = word;
    endtask

    always @(negedge clk) begin : retire_monitor
        retire_t exp_rec;
        if (!rst_i && retire_valid_o) begin
            retire_cnt++;
            assert (exp_q.size() != 0) else begin
                $display("error: %s retire strobe came with no instruction in flight",
                         test_name(T_TIMING));
                errors[T_TIMING]++;
            end
            if (exp_q.size() != 0) begin
                exp_rec = exp_q.pop_front();
                check_value(T_TIMING, "retire cycle", exp_rec.cycle, cycle_cnt);
                check_value(exp_rec.test, "illegal", exp_rec.illegal, retire_illegal_o);
                check_value(exp_rec.test, "we", exp_rec.we, retire_we_o);
                check_value(exp_rec.test, "data", exp_rec.data, retire_data_o);
                if (!exp_rec.illegal) check_value(exp_rec.test, "rd", exp_rec.rd, retire_rd_o);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the instruction stream retired");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : stimulus
        int issued;
        int drain;
        int total_checks;
        int total_errors;
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        issued       = 0;
        drain        = 0;
        total_checks = 0;
        total_errors = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            checks[i] = 0;
            errors[i] = 0;
        end
        for (int i = 0; i < `REG_NUM; i++) model_regs[i] = '0;
        for (int i = 0; i < 3; i++) hist_rd[i] = 3'd0;
        repeat (10) @(negedge clk);
        rst_i = 1'b0;
        repeat (8) begin    // quiet pipeline with no strobe
            @(negedge clk);
            check_value(T_TIMING, "idle retire_valid", 0, retire_valid_o);
            check_value(T_TIMING, "idle retire_we", 0, retire_we_o);
        end
        while (issued < NUM_INST) begin
            @(negedge clk);
            if (take_bits(2) == 0) begin
                inst_valid_i = 1'b0;
            end else begin
                issue_instruction();
                issued++;
            end
        end
        @(negedge clk);
        inst_valid_i = 1'b0;
        while (exp_q.size() != 0 && drain < 20) begin
            @(negedge clk);
            drain++;
        end
        repeat (5) @(negedge clk);
        @(posedge clk);
        check_value(T_COUNTS, "retires", strobe_cnt, retire_cnt);
        check_value(T_COUNTS, "queue left", 0, exp_q.size());
        for (int i = 0; i < NUM_TESTS; i++) begin
            $display("%-14s checks %0d errors %0d", test_name(i), checks[i], errors[i]);
            total_checks += checks[i];
            total_errors += errors[i];
        end
        $display("tests %0d strobes %0d checks %0d errors %0d", NUM_TESTS, strobe_cnt,
                 total_checks, total_errors);
        if (total_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
